/* msx_cfg_pkg.sv */
package msx_cfg_pkg;

    // Table depths
    localparam int LAYOUT_ENTRIES = 64;          // 4 slots x 4 subslots x 4 blocks
    localparam int RAM_ENTRIES    = 16;          // Regions reachable through ref_ram

    // Address geometry
    localparam int SDRAM_AW    = 27;             // SDRAM byte address width
    localparam int BLOCK_SHIFT = 14;             // 16 KB per block

    // Secondary slot select register, only decoded on expanded slots
    localparam logic [15:0] SUBSLOT_REG_ADDR = 16'hFFFF;

    // ASCII16 bank register windows
    localparam logic [15:0] ASCII16_BANK0_LO = 16'h6000;    // Selects the page at 4000
    localparam logic [15:0] ASCII16_BANK0_HI = 16'h67FF;
    localparam logic [15:0] ASCII16_BANK1_LO = 16'h7000;    // Selects the page at 8000
    localparam logic [15:0] ASCII16_BANK1_HI = 16'h77FF;

    // Cartridge mapper kinds kept in this core
    typedef enum logic [1:0] {
        MAPPER_NONE    = 2'd0,                   // Linear ROM
        MAPPER_ASCII16 = 2'd1,                   // Two 16 KB switchable banks
        MAPPER_RAM     = 2'd2                    // Plain linear RAM
    } mapper_t;

    // One slot layout entry
    typedef struct packed {
        logic [3:0] ref_ram;                     // Index into the RAM lookup table
        logic [1:0] offset_ram;                  // Block where the region starts
        mapper_t    mapper;
    } block_t;

    // One memory region in SDRAM
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;               // Region base
        logic [15:0]         size;               // Size in 16 KB blocks, power of two
        logic                ro;                 // Region is ROM
    } lookup_ram_t;

endpackage

/* msx_bus_pkg.sv */
package msx_bus_pkg;

    localparam int CPU_AW = 16;                  // Z80 address bus
    localparam int CPU_DW = 8;                   // Z80 data bus

    // CPU bus cycle, one strobe per access
    typedef struct packed {
        logic              valid;
        logic              wr;                   // 1 for a write cycle
        logic [CPU_AW-1:0] addr;
        logic [CPU_DW-1:0] data;                 // Write data
        logic [1:0]        slot;                 // Active primary slot
    } cpu_req_t;

    // Stage 1 to stage 2
    typedef struct packed {
        logic                valid;
        logic                wr;
        logic [CPU_DW-1:0]   data;
        logic [CPU_AW-1:0]   addr;
        msx_cfg_pkg::block_t entry;              // Resolved layout entry
        logic [1:0]          block;              // 16 KB page of the access
        logic                sub_hit;            // Absorbed by the FFFF register
        logic [CPU_DW-1:0]   sub_data;           // Inverted register readback
    } slot_stage_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic                            valid;
        logic                            wr;
        logic [CPU_DW-1:0]               data;
        logic [3:0]                      ref_ram;
        logic [msx_cfg_pkg::SDRAM_AW-1:0] offset;    // Offset inside the region
        logic                            mapped;     // Access reaches memory
        logic                            sub_hit;
        logic [CPU_DW-1:0]               sub_data;
    } map_stage_t;

    // Request to the SDRAM controller
    typedef struct packed {
        logic                            ce;
        logic                            rnw;        // 1 for read
        logic [msx_cfg_pkg::SDRAM_AW-1:0] addr;
        logic [CPU_DW-1:0]               din;
    } sdram_req_t;

    // Subslot register readback
    typedef struct packed {
        logic              valid;
        logic [CPU_DW-1:0] data;
    } sub_resp_t;

endpackage

/* slot_decoder.sv */
`timescale 1ns/1ps

module slot_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  msx_bus_pkg::cpu_req_t    req,
    input  logic [3:0]               expander_en,       // One bit per primary slot
    input  msx_cfg_pkg::block_t      slot_layout [msx_cfg_pkg::LAYOUT_ENTRIES],
    output msx_bus_pkg::slot_stage_t s1
);

    logic [7:0] sub_reg [4];         // FFFF register of each primary slot
    logic [1:0] blk;                 // Page of the access
    logic       expanded;
    logic [1:0] subslot;
    logic [5:0] layout_id;
    logic       sub_acc;             // Access is taken by the FFFF register

    assign blk      = req.addr[15:14];
    assign expanded = expander_en[req.slot];

    // Two bits per page, page 0 in the low bits
    // Unexpanded slots always sit on subslot 0
    assign subslot = expanded ? sub_reg[req.slot][{blk, 1'b0} +: 2] : 2'b00;

    assign layout_id = {req.slot, subslot, blk};    // Same packing as the layout table

    // FFFF is ordinary memory unless the slot has an expander
    assign sub_acc = req.valid && expanded
                     && (req.addr == msx_cfg_pkg::SUBSLOT_REG_ADDR);

    // Secondary slot registers
    // A write is visible to the very next request
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                sub_reg[i] <= '0;
            end
        end else if (sub_acc && req.wr) begin
            sub_reg[req.slot] <= req.data;              // Stored raw
        end
    end

    // Stage register
    always_ff @(posedge clk) begin
        s1.wr       <= req.wr;
        s1.data     <= req.data;
        s1.addr     <= req.addr;
        s1.entry    <= slot_layout[layout_id];
        s1.block    <= blk;
        s1.sub_data <= ~sub_reg[req.slot];              // Hardware reads back inverted
        if (rst) begin
            s1.valid   <= 1'b0;
            s1.sub_hit <= 1'b0;
        end else begin
            s1.valid   <= req.valid;
            s1.sub_hit <= sub_acc;
        end
    end

    // A subslot hit is always a live FFFF access
    a_sub_hit_valid: assert property (
        @(posedge clk) disable iff (rst)
        s1.sub_hit |-> s1.valid && (s1.addr == msx_cfg_pkg::SUBSLOT_REG_ADDR)
    );

endmodule

/* bank_mapper.sv */
`timescale 1ns/1ps

module bank_mapper (
    input  logic                     clk,
    input  logic                     rst,
    input  msx_bus_pkg::slot_stage_t s1,
    input  msx_cfg_pkg::lookup_ram_t lookup_ram [msx_cfg_pkg::RAM_ENTRIES],
    output msx_bus_pkg::map_stage_t  s2
);

    logic [7:0]  bank0 [msx_cfg_pkg::RAM_ENTRIES];   // ASCII16 page at 4000, per region
    logic [7:0]  bank1 [msx_cfg_pkg::RAM_ENTRIES];   // ASCII16 page at 8000, per region
    logic [3:0]  ref_ram;
    logic        in_win0;
    logic        in_win1;
    logic        win_wr;                // Write into either bank window
    logic        bank_wr;               // Bank register update this cycle
    logic [1:0]  lin_blk;
    logic [7:0]  bank_sel;
    logic [15:0] bank_masked;
    logic        mapped;
    logic [msx_cfg_pkg::SDRAM_AW-1:0] blk_num;       // Block index inside the region
    logic [msx_cfg_pkg::SDRAM_AW-1:0] in_blk;        // Byte inside the block
    logic [msx_cfg_pkg::SDRAM_AW-1:0] offset;

    assign ref_ram = s1.entry.ref_ram;

    assign in_win0 = (s1.addr >= msx_cfg_pkg::ASCII16_BANK0_LO)
                     && (s1.addr <= msx_cfg_pkg::ASCII16_BANK0_HI);
    assign in_win1 = (s1.addr >= msx_cfg_pkg::ASCII16_BANK1_LO)
                     && (s1.addr <= msx_cfg_pkg::ASCII16_BANK1_HI);
    assign win_wr  = s1.wr && (in_win0 || in_win1);
    assign bank_wr = s1.valid && !s1.sub_hit && win_wr
                     && (s1.entry.mapper == msx_cfg_pkg::MAPPER_ASCII16);

    assign lin_blk  = s1.block - s1.entry.offset_ram;             // Region may start mid slot
    assign bank_sel = (s1.block == 2'd2) ? bank1[ref_ram] : bank0[ref_ram];
    // Size is a power of two so size-1 is the block mask
    assign bank_masked = {8'h00, bank_sel} & (lookup_ram[ref_ram].size - 16'd1);

    assign in_blk = {{(msx_cfg_pkg::SDRAM_AW - msx_cfg_pkg::BLOCK_SHIFT){1'b0}},
                     s1.addr[msx_cfg_pkg::BLOCK_SHIFT-1:0]};

    always_comb begin
        blk_num = '0;
        mapped  = 1'b0;
        case (s1.entry.mapper)
            msx_cfg_pkg::MAPPER_NONE,
            msx_cfg_pkg::MAPPER_RAM: begin
                blk_num[1:0] = lin_blk;
                mapped       = 1'b1;               // ROM writes are caught in stage 3
            end
            msx_cfg_pkg::MAPPER_ASCII16: begin
                blk_num[15:0] = bank_masked;
                // Only pages 1 and 2 are banked, bank writes never reach memory
                mapped = ((s1.block == 2'd1) || (s1.block == 2'd2)) && !win_wr;
            end
            default: mapped = 1'b0;
        endcase
        offset = (blk_num << msx_cfg_pkg::BLOCK_SHIFT) | in_blk;
    end

    // Bank registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < msx_cfg_pkg::RAM_ENTRIES; i++) begin
                bank0[i] <= '0;
                bank1[i] <= '0;
            end
        end else if (bank_wr) begin
            if (in_win0) begin
                bank0[ref_ram] <= s1.data;
            end else begin
                bank1[ref_ram] <= s1.data;
            end
        end
    end

    // Stage register
    always_ff @(posedge clk) begin
        s2.wr       <= s1.wr;
        s2.data     <= s1.data;
        s2.ref_ram  <= ref_ram;
        s2.offset   <= offset;
        s2.mapped   <= mapped;
        s2.sub_data <= s1.sub_data;
        if (rst) begin
            s2.valid   <= 1'b0;
            s2.sub_hit <= 1'b0;
        end else begin
            s2.valid   <= s1.valid;
            s2.sub_hit <= s1.sub_hit;
        end
    end

endmodule

/* mem_addr_gen.sv */
`timescale 1ns/1ps

module mem_addr_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  msx_bus_pkg::map_stage_t  s2,
    input  msx_cfg_pkg::lookup_ram_t lookup_ram [msx_cfg_pkg::RAM_ENTRIES],
    output msx_bus_pkg::sdram_req_t  sdram_req,
    output msx_bus_pkg::sub_resp_t   sub_resp
);

    logic [msx_cfg_pkg::SDRAM_AW-1:0] base;      // Region start in SDRAM
    logic                             ro;

    assign base = lookup_ram[s2.ref_ram].addr;
    assign ro   = lookup_ram[s2.ref_ram].ro;

    always_ff @(posedge clk) begin
        sdram_req.addr <= base + s2.offset;
        sdram_req.din  <= s2.data;
        sdram_req.rnw  <= !s2.wr || ro;           // ROM writes turn into reads
        sub_resp.data  <= s2.sub_data;
        if (rst) begin
            sdram_req.ce   <= 1'b0;
            sub_resp.valid <= 1'b0;
        end else begin
            // FFFF on an expanded slot never touches SDRAM
            sdram_req.ce   <= s2.valid && s2.mapped && !s2.sub_hit;
            sub_resp.valid <= s2.valid && s2.sub_hit && !s2.wr;   // Only reads answer
        end
    end

    // One cycle carries either a memory access or a register readback
    a_ce_resp_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(sdram_req.ce && sub_resp.valid)
    );

endmodule

/* msx_slots.sv */
`timescale 1ns/1ps

module msx_slots (
    input  logic                     clk,
    input  logic                     rst,
    input  msx_bus_pkg::cpu_req_t    cpu_req,
    input  msx_cfg_pkg::block_t      slot_layout [msx_cfg_pkg::LAYOUT_ENTRIES],
    input  msx_cfg_pkg::lookup_ram_t lookup_ram  [msx_cfg_pkg::RAM_ENTRIES],
    input  logic [3:0]               expander_en,
    output msx_bus_pkg::sdram_req_t  sdram_req,
    output msx_bus_pkg::sub_resp_t   sub_resp
);

    msx_bus_pkg::slot_stage_t s1;    // Slot, subslot and layout resolved
    msx_bus_pkg::map_stage_t  s2;    // Mapper applied

    // Stage 1, slot and subslot
    slot_decoder i_slot_decoder (
        .clk         (clk),
        .rst         (rst),
        .req         (cpu_req),
        .expander_en (expander_en),
        .slot_layout (slot_layout),
        .s1          (s1)
    );

    // Stage 2, cartridge mapper
    bank_mapper i_bank_mapper (
        .clk        (clk),
        .rst        (rst),
        .s1         (s1),
        .lookup_ram (lookup_ram),
        .s2         (s2)
    );

    // Stage 3, SDRAM request
    mem_addr_gen i_mem_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .s2         (s2),
        .lookup_ram (lookup_ram),
        .sdram_req  (sdram_req),
        .sub_resp   (sub_resp)
    );

endmodule

/* tb_msx_slots.sv */
`timescale 1ns/1ps

module tb_msx_slots;

    // Expected response of one request
    typedef struct packed {
        logic        ce;
        logic        rnw;
        logic [26:0] addr;
        logic        chk_din;                    // Write data must reach the SDRAM port
        logic [7:0]  din;
        logic        rv;                         // Subslot readback expected
        logic [7:0]  rdata;
    } exp_t;

    localparam int DRAIN_TIMEOUT = 20;           // Cycles allowed to flush the pipeline

    logic                     clk;
    logic                     rst;
    msx_bus_pkg::cpu_req_t    cpu_req;
    msx_cfg_pkg::block_t      slot_layout [msx_cfg_pkg::LAYOUT_ENTRIES];
    msx_cfg_pkg::lookup_ram_t lookup_ram  [msx_cfg_pkg::RAM_ENTRIES];
    logic [3:0]               expander_en;
    msx_bus_pkg::sdram_req_t  sdram_req;
    msx_bus_pkg::sub_resp_t   sub_resp;

    // Stimulus table
    msx_bus_pkg::cpu_req_t row_req [$];
    exp_t                  row_exp [$];
    string                 row_name [$];
    bit                    row_rnd [$];          // Data byte replaced by a random one

    // Expectations in flight, three deep once the pipe is full
    exp_t  exp_q [$];
    string name_q [$];
    bit    is_row_q [$];

    integer seed;
    int     errors;
    int     checks;
    int     rows_checked;
    int     waited;

    msx_slots i_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .slot_layout (slot_layout),
        .lookup_ram  (lookup_ram),
        .expander_en (expander_en),
        .sdram_req   (sdram_req),
        .sub_resp    (sub_resp)
    );

    always #5 clk = ~clk;                        // 100 MHz

    function automatic msx_cfg_pkg::block_t make_block(input logic [3:0] ref_ram,
                                                       input logic [1:0] off,
                                                       input logic [1:0] kind);
        msx_cfg_pkg::block_t b;
        b.ref_ram    = ref_ram;
        b.offset_ram = off;
        b.mapper     = msx_cfg_pkg::mapper_t'(kind);
        return b;
    endfunction

    function automatic msx_cfg_pkg::lookup_ram_t make_region(input logic [26:0] base,
                                                             input logic [15:0] size,
                                                             input logic ro);
        msx_cfg_pkg::lookup_ram_t r;
        r.addr = base;
        r.size = size;
        r.ro   = ro;
        return r;
    endfunction

    task automatic add_row(input string name, input logic [1:0] slot, input logic wr,
                           input logic [15:0] addr, input logic [7:0] data, input bit rnd,
                           input logic ce, input logic rnw, input logic [26:0] eaddr,
                           input logic rv, input logic [7:0] rdata);
        msx_bus_pkg::cpu_req_t r;
        exp_t                  e;
        r.valid   = 1'b1;
        r.wr      = wr;
        r.addr    = addr;
        r.data    = data;
        r.slot    = slot;
        e.ce      = ce;
        e.rnw     = rnw;
        e.addr    = eaddr;
        e.chk_din = ce && wr;
        e.din     = data;
        e.rv      = rv;
        e.rdata   = rdata;
        row_req.push_back(r);
        row_exp.push_back(e);
        row_name.push_back(name);
        row_rnd.push_back(rnd);
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("ERROR %s %s expected %0h actual %0h", name, field, exp, act);
    endtask

    // Compare the oldest expectation with what the DUT shows now
    task automatic check_oldest();
        exp_t  e;
        string name;
        bit    is_row;
        e      = exp_q.pop_front();
        name   = name_q.pop_front();
        is_row = is_row_q.pop_front();
        checks++;
        if (sdram_req.ce !== e.ce) report_mismatch(name, "ce", e.ce, sdram_req.ce);
        if (e.ce && sdram_req.rnw !== e.rnw) report_mismatch(name, "rnw", e.rnw, sdram_req.rnw);
        if (e.ce && sdram_req.addr !== e.addr) report_mismatch(name, "addr", e.addr, sdram_req.addr);
        if (e.chk_din && sdram_req.din !== e.din) report_mismatch(name, "din", e.din, sdram_req.din);
        if (sub_resp.valid !== e.rv) report_mismatch(name, "sub_valid", e.rv, sub_resp.valid);
        if (e.rv && sub_resp.data !== e.rdata) report_mismatch(name, "sub_data", e.rdata, sub_resp.data);
        if (is_row) rows_checked++;
    endtask

    // One cycle: check what left the pipe, then drive the next request
    task automatic step(input msx_bus_pkg::cpu_req_t req, input exp_t e,
                        input string name, input bit is_row);
        @(posedge clk);
        #1;
        if (exp_q.size() == 3) check_oldest();   // Three cycles of latency
        cpu_req = req;
        exp_q.push_back(e);
        name_q.push_back(name);
        is_row_q.push_back(is_row);
    endtask

    initial begin
        msx_bus_pkg::cpu_req_t req;
        msx_bus_pkg::cpu_req_t idle_req;
        exp_t                  e;
        exp_t                  idle_exp;
        logic [31:0]           rnd_word;
        seed         = 32'hd75a_aeac;
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_req      = '0;
        idle_req     = '0;
        idle_exp     = '0;                       // Nothing leaves the pipe
        expander_en  = 4'b0010;                  // Only slot 1 has an expander
        errors       = 0;
        checks       = 0;
        rows_checked = 0;

        // Layout, unused mapper encoding 3 decodes as unmapped
        for (int i = 0; i < msx_cfg_pkg::LAYOUT_ENTRIES; i++) begin
            slot_layout[i] = make_block(4'd0, 2'd0, 2'd3);
        end
        for (int b = 0; b < 4; b++) begin
            slot_layout[b]      = make_block(4'd0, 2'd0, msx_cfg_pkg::MAPPER_RAM);      // Slot 0
            slot_layout[24 + b] = make_block(4'd1, 2'd0, msx_cfg_pkg::MAPPER_ASCII16);  // 1-2
        end
        slot_layout[33] = make_block(4'd2, 2'd1, msx_cfg_pkg::MAPPER_NONE);   // ROM at 4000
        slot_layout[34] = make_block(4'd2, 2'd1, msx_cfg_pkg::MAPPER_NONE);
        for (int i = 0; i < msx_cfg_pkg::RAM_ENTRIES; i++) begin
            lookup_ram[i] = '0;
        end
        lookup_ram[0] = make_region(27'h040_0000, 16'd4, 1'b0);   // 64 KB RAM
        lookup_ram[1] = make_region(27'h010_0000, 16'd8, 1'b1);   // 128 KB ASCII16 ROM
        lookup_ram[2] = make_region(27'h020_8000, 16'd2, 1'b1);   // 32 KB plain ROM

        //      name                slot wr addr      data  rnd ce rnw exp_addr     rv rdata
        add_row("s0_rd_b0",         0, 0, 16'h0123, 8'h00, 0, 1, 1, 27'h040_0123, 0, 8'h00);
        add_row("s0_rd_b1",         0, 0, 16'h4567, 8'h00, 0, 1, 1, 27'h040_4567, 0, 8'h00);
        add_row("s0_rd_b2",         0, 0, 16'h89ab, 8'h00, 0, 1, 1, 27'h040_89ab, 0, 8'h00);
        add_row("s0_rd_b3",         0, 0, 16'hcdef, 8'h00, 0, 1, 1, 27'h040_cdef, 0, 8'h00);
        add_row("s0_ffff_wr",       0, 1, 16'hffff, 8'h00, 1, 1, 0, 27'h040_ffff, 0, 8'h00);
        add_row("s0_ffff_rd",       0, 0, 16'hffff, 8'h00, 0, 1, 1, 27'h040_ffff, 0, 8'h00);
        add_row("s0_wr_b1",         0, 1, 16'h5000, 8'h00, 1, 1, 0, 27'h040_5000, 0, 8'h00);
        add_row("s1_sub0_unmapped", 1, 0, 16'h4000, 8'h00, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("s1_ffff_wr",       1, 1, 16'hffff, 8'haa, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("s1_ffff_rd",       1, 0, 16'hffff, 8'h00, 0, 0, 1, 27'h000_0000, 1, 8'h55);
        add_row("a16_bank0_wr",     1, 1, 16'h6000, 8'h03, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("a16_rd_4000",      1, 0, 16'h4000, 8'h00, 0, 1, 1, 27'h010_c000, 0, 8'h00);
        add_row("a16_bank1_wr",     1, 1, 16'h7000, 8'h0d, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("a16_rd_8123",      1, 0, 16'h8123, 8'h00, 0, 1, 1, 27'h011_4123, 0, 8'h00);
        add_row("a16_rd_7fff",      1, 0, 16'h7fff, 8'h00, 0, 1, 1, 27'h010_ffff, 0, 8'h00);
        add_row("a16_rd_b0",        1, 0, 16'h1000, 8'h00, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("a16_rd_b3",        1, 0, 16'hc000, 8'h00, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("a16_rom_wr",       1, 1, 16'h9000, 8'h77, 0, 1, 1, 27'h011_5000, 0, 8'h00);
        add_row("s2_rd_b1",         2, 0, 16'h4010, 8'h00, 0, 1, 1, 27'h020_8010, 0, 8'h00);
        add_row("s2_rd_b2",         2, 0, 16'hbfff, 8'h00, 0, 1, 1, 27'h020_ffff, 0, 8'h00);
        add_row("s2_rom_wr",        2, 1, 16'h8100, 8'h5a, 0, 1, 1, 27'h020_c100, 0, 8'h00);
        add_row("s2_rd_b0_unmapped", 2, 0, 16'h0000, 8'h00, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("s3_rd_unmapped",   3, 0, 16'h8000, 8'h00, 0, 0, 1, 27'h000_0000, 0, 8'h00);
        add_row("s1_ffff_rd_again", 1, 0, 16'hffff, 8'h00, 0, 0, 1, 27'h000_0000, 1, 8'h55);

        // Reset, outputs must stay quiet throughout
        repeat (8) begin
            @(posedge clk);
            #1;
            if (sdram_req.ce !== 1'b0 || sub_resp.valid !== 1'b0) begin
                errors++;
                $display("SDRAM request or subslot response active during reset");
            end
        end
        rst = 1'b0;

        for (int i = 0; i < 6; i++) begin
            step(idle_req, idle_exp, "reset_idle", 1'b0);   // Nothing strobed, nothing out
        end

        // Back-to-back, one row per cycle
        for (int i = 0; i < row_req.size(); i++) begin
            req = row_req[i];
            e   = row_exp[i];
            if (row_rnd[i]) begin
                rnd_word = $random(seed);
                req.data = rnd_word[7:0];
                e.din    = rnd_word[7:0];
            end
            step(req, e, row_name[i], 1'b1);
        end

        // Flush the pipe
        waited = 0;
        while (rows_checked < row_req.size() && waited < DRAIN_TIMEOUT) begin
            step(idle_req, idle_exp, "drain", 1'b0);
            waited++;
        end
        if (rows_checked < row_req.size()) begin
            errors++;
            $display("Timed out before every table row was checked");
        end

        $display("Checks: %0d  table rows: %0d  errors: %0d", checks, row_req.size(), errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
msx_cfg_pkg.sv
msx_bus_pkg.sv
slot_decoder.sv
bank_mapper.sv
mem_addr_gen.sv
msx_slots.sv
tb_msx_slots.sv
